//--- verilog.f
+incdir+.
spi_solo_pkg.sv
spi_sync_fifo.sv
spi_clk_phase.sv
spi_bus_seq.sv
spi_rx_shift.sv
spi_solo_top.sv
tb_spi_solo.sv

//--- Bender.yml
package:
  name: spi_solo

sources:
  - include_dirs:
      - .
    files:
      - spi_solo_pkg.sv
      - spi_sync_fifo.sv
      - spi_clk_phase.sv
      - spi_bus_seq.sv
      - spi_rx_shift.sv
      - spi_solo_top.sv
      - target: test
        include_dirs:
          - .
        files:
          - tb_spi_solo.sv

//--- tb_spi_solo.sv
//////////////////////////////
// spi solo testbench
// mode 0 peripheral model, frame stimulus
// and checks on bus timing and data
//////////////////////////////
`timescale 1ns/1ps
`include "spi_solo_cfg.svh"

module tb_spi_solo;
  import spi_solo_pkg::*;

  localparam time PERIOD    = 40ns;
  localparam time DRIVE_DLY = 2ns;
  // minimum gap around the select window
  localparam time SS_GAP    = `SPI_SS_PERIODS * `SPI_CLK_RATIO * PERIOD;

  // frame length in SCK periods, wait only counts with a read phase
  function automatic int frame_periods(input int tx, input int wt, input int rx);
    return 4 * `SPI_SS_PERIODS + 8 * tx + ((rx != 0) ? wt : 0) + 8 * rx;
  endfunction

  localparam int CYCLE_LIMIT = 3 * `SPI_CLK_RATIO *
    (frame_periods(3, 0, 0) + frame_periods(2, 2, 3) + frame_periods(1, 1, 1)) + 200;

  logic     i_ext_spi_clk_x;
  logic     i_srst;
  logic     go;
  spi_cmd_t cmd;
  logic     idle;
  logic     tx_enqueue;
  byte_t    tx_data;
  logic     tx_ready;
  logic     rx_dequeue;
  byte_t    rx_data;
  logic     rx_avail;
  spi_bus_t spi_bus;
  logic     cipo = 1'b0;
  logic     sck;
  logic     csn;
  logic     copi;

  ////////////////////////////// peripheral model state
  byte_t sent_q[$];
  byte_t resp_q[$];
  byte_t cap_q[$];
  byte_t cap_shreg;
  int    cap_bits;
  // first rise index that carries reply data
  int    rx_first = 0;
  int    rises = 0;
  int    frames = 0;
  int    cycles = 0;
  time   t_csn_fall;
  time   t_last_fall;
  logic  no_rx_expected;

  assign sck  = spi_bus.sck;
  assign csn  = spi_bus.csn;
  assign copi = spi_bus.copi;

  spi_solo_top u_spi_solo_top (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .go_i            (go),
    .cmd_i           (cmd),
    .idle_o          (idle),
    .tx_enqueue_i    (tx_enqueue),
    .tx_data_i       (tx_data),
    .tx_ready_o      (tx_ready),
    .rx_dequeue_i    (rx_dequeue),
    .rx_data_o       (rx_data),
    .rx_avail_o      (rx_avail),
    .spi_o           (spi_bus),
    .cipo_i          (cipo)
  );

  initial i_ext_spi_clk_x = 1'b0;
  always #(PERIOD / 2) i_ext_spi_clk_x = ~i_ext_spi_clk_x;

  ////////////////////////////// error reporting
  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("FAIL %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic report_problem(input string what);
    $display("FAIL %0t ns %s", $time, what);
    abort_run();
  endtask

  // run limit
  always @(posedge i_ext_spi_clk_x) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      report_problem("timeout, the run did not finish within the cycle limit");
    end
  end

  ////////////////////////////// peripheral model
  // reply bit for rise number n, zero outside the read phase
  function automatic logic reply_bit(input int n);
    int k;
    k = n - rx_first;
    if ((k < 0) || (k >= 8 * resp_q.size())) begin
      return 1'b0;
    end
    return resp_q[k / 8][7 - (k % 8)];
  endfunction

  // new frame, first reply bit ready before the first rise
  always @(negedge csn) begin
    frames++;
    rises = 0;
    cap_bits = 0;
    cap_q.delete();
    t_csn_fall = $time;
    cipo = reply_bit(0);
  end

  always @(posedge sck) begin
    if (!csn) begin
      if (rises == 0) begin
        assert ($time - t_csn_fall >= SS_GAP)
          else report_problem("sck rose too soon after csn fell");
      end
      rises++;
      cap_shreg = {cap_shreg[6:0], copi};
      cap_bits++;
      if (cap_bits % 8 == 0) begin
        cap_q.push_back(cap_shreg);
      end
    end
  end

  // mode 0 output changes on the falling edge
  always @(negedge sck) begin
    if (!csn) begin
      t_last_fall = $time;
      cipo = reply_bit(rises);
    end
  end

  always @(posedge csn) begin
    if (frames > 0) begin
      assert ($time - t_last_fall >= SS_GAP)
        else report_problem("csn rose too soon after the last sck fall");
    end
  end

  ////////////////////////////// bus checks
  a_mode0 : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    csn |-> !sck)
    else report_problem("sck high while csn high");

  a_no_rx : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    no_rx_expected |-> !rx_avail)
    else report_problem("receive data appeared during a write-only frame");

  ////////////////////////////// stimulus
  task automatic step();
    @(posedge i_ext_spi_clk_x);
    #DRIVE_DLY;
  endtask

  task automatic push_byte(input byte_t b);
    step();
    tx_enqueue = 1'b1;
    tx_data = b;
    step();
    tx_enqueue = 1'b0;
  endtask

  // random payload and reply, both queued before go
  task automatic load_frame(input int tx, input int wt, input int rx);
    byte_t b;
    sent_q.delete();
    resp_q.delete();
    rx_first = 8 * tx + ((rx != 0) ? wt : 0);
    for (int i = 0; i < tx; i++) begin
      b = byte_t'($urandom);
      sent_q.push_back(b);
      push_byte(b);
    end
    for (int i = 0; i < rx; i++) begin
      resp_q.push_back(byte_t'($urandom));
    end
  endtask

  task automatic start_frame(input int tx, input int wt, input int rx);
    step();
    go = 1'b1;
    cmd.tx_len = len_t'(tx);
    cmd.wait_cyc = wait_t'(wt);
    cmd.rx_len = len_t'(rx);
    step();
    go = 1'b0;
  endtask

  task automatic wait_frame_end();
    while (!idle) begin
      step();
    end
  endtask

  task automatic check_frame(input int exp_rises);
    assert (rises == exp_rises) else report_mismatch("sck rises", rises, exp_rises);
    assert (cap_q.size() >= sent_q.size())
      else report_mismatch("copi byte count", cap_q.size(), sent_q.size());
    foreach (sent_q[i]) begin
      assert (cap_q[i] == sent_q[i]) else report_mismatch("copi byte", cap_q[i], sent_q[i]);
    end
  endtask

  // pop each expected reply byte, then the queue must be empty
  task automatic drain_rx();
    for (int n = 0; n < resp_q.size(); n++) begin
      assert (rx_avail) else report_mismatch("rx_avail_o", rx_avail, 1);
      assert (rx_data == resp_q[n]) else report_mismatch("rx_data_o", rx_data, resp_q[n]);
      rx_dequeue = 1'b1;
      step();
      rx_dequeue = 1'b0;
    end
    assert (!rx_avail) else report_mismatch("rx_avail_o", rx_avail, 0);
  endtask

  initial begin
    int frames_before;
    void'($urandom(32'h0737_4c74));
    i_srst = 1'b1;
    go = 1'b0;
    cmd = '0;
    tx_enqueue = 1'b0;
    tx_data = '0;
    rx_dequeue = 1'b0;
    no_rx_expected = 1'b0;
    repeat (5) @(posedge i_ext_spi_clk_x);
    #DRIVE_DLY;
    i_srst = 1'b0;
    step();

    // reset state
    assert (csn) else report_mismatch("spi_o.csn", csn, 1);
    assert (!sck) else report_mismatch("spi_o.sck", sck, 0);
    assert (idle) else report_mismatch("idle_o", idle, 1);
    assert (tx_ready) else report_mismatch("tx_ready_o", tx_ready, 1);
    assert (!rx_avail) else report_mismatch("rx_avail_o", rx_avail, 0);

    // write-only frame
    load_frame(3, 0, 0);
    no_rx_expected = 1'b1;
    start_frame(3, 0, 0);
    wait_frame_end();
    check_frame(24);
    no_rx_expected = 1'b0;

    // write, wait, then read
    load_frame(2, 2, 3);
    start_frame(2, 2, 3);
    wait_frame_end();
    check_frame(8 * 2 + 2 + 8 * 3);
    drain_rx();

    // second go during a frame must be dropped
    load_frame(1, 1, 1);
    frames_before = frames;
    start_frame(1, 1, 1);
    repeat (3) step();
    go = 1'b1;
    cmd.tx_len = len_t'(3);
    cmd.wait_cyc = wait_t'(0);
    cmd.rx_len = len_t'(0);
    step();
    go = 1'b0;
    wait_frame_end();
    check_frame(8 + 1 + 8);
    drain_rx();
    repeat (4 * `SPI_CLK_RATIO) step();
    assert (idle) else report_mismatch("idle_o", idle, 1);
    assert (frames == frames_before + 1)
      else report_mismatch("frame count", frames, frames_before + 1);

    // fill the transmit FIFO
    for (int i = 0; i < `SPI_FIFO_DEPTH; i++) begin
      assert (tx_ready) else report_mismatch("tx_ready_o", tx_ready, 1);
      push_byte(byte_t'($urandom));
    end
    assert (!tx_ready) else report_mismatch("tx_ready_o", tx_ready, 0);

    $display("No errors");
    $finish;
  end

endmodule

//--- spi_solo_top.sv
//////////////////////////////
// spi solo top level
// mode 0 single-peripheral master with
// transmit and receive byte FIFOs
//////////////////////////////
`timescale 1ns/1ps
`include "spi_solo_cfg.svh"

module spi_solo_top (
  input  logic                   i_ext_spi_clk_x,
  input  logic                   i_srst,
  // frame request
  input  logic                   go_i,
  input  spi_solo_pkg::spi_cmd_t cmd_i,
  output logic                   idle_o,
  // transmit queue
  input  logic                   tx_enqueue_i,
  input  spi_solo_pkg::byte_t    tx_data_i,
  output logic                   tx_ready_o,
  // receive queue
  input  logic                   rx_dequeue_i,
  output spi_solo_pkg::byte_t    rx_data_o,
  output logic                   rx_avail_o,
  // bus
  output spi_solo_pkg::spi_bus_t spi_o,
  input  logic                   cipo_i
);
  import spi_solo_pkg::*;

  // transmit side
  byte_t tx_head;
  logic  tx_pop;
  logic  tx_empty;
  logic  tx_full;
  // receive side
  byte_t rx_byte;
  logic  rx_push;
  logic  rx_empty;
  // bus timing
  logic  sck_lvl;
  logic  rise_tick;
  logic  fall_tick;
  logic  in_rx;

  assign tx_ready_o = !tx_full;
  assign rx_avail_o = !rx_empty;

  ////////////////////////////// FIFOs
  spi_sync_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_tx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .wr_i            (tx_enqueue_i),
    .wr_data_i       (tx_data_i),
    .rd_i            (tx_pop),
    .rd_data_o       (tx_head),
    .empty_o         (tx_empty),
    .full_o          (tx_full)
  );

  // a full receive FIFO drops bytes, flag not needed
  spi_sync_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_rx_fifo (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .wr_i            (rx_push),
    .wr_data_i       (rx_byte),
    .rd_i            (rx_dequeue_i),
    .rd_data_o       (rx_data_o),
    .empty_o         (rx_empty),
    .full_o          ()
  );

  ////////////////////////////// bus engine
  spi_clk_phase u_clk_phase (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .sck_lvl_o       (sck_lvl),
    .rise_tick_o     (rise_tick),
    .fall_tick_o     (fall_tick)
  );

  spi_bus_seq u_bus_seq (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .go_i            (go_i),
    .cmd_i           (cmd_i),
    .idle_o          (idle_o),
    .sck_lvl_i       (sck_lvl),
    .fall_tick_i     (fall_tick),
    .tx_head_i       (tx_head),
    .tx_empty_i      (tx_empty),
    .tx_pop_o        (tx_pop),
    .in_rx_o         (in_rx),
    .spi_o           (spi_o)
  );

  spi_rx_shift u_rx_shift (
    .i_ext_spi_clk_x (i_ext_spi_clk_x),
    .i_srst          (i_srst),
    .rise_tick_i     (rise_tick),
    .in_rx_i         (in_rx),
    .cipo_i          (cipo_i),
    .rx_push_o       (rx_push),
    .rx_byte_o       (rx_byte)
  );

endmodule

//--- spi_rx_shift.sv
//////////////////////////////
// receive shifter
// samples CIPO on SCK rise ticks
// and pushes each full byte
//////////////////////////////
`timescale 1ns/1ps
`include "spi_solo_cfg.svh"

module spi_rx_shift (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  logic                rise_tick_i,
  input  logic                in_rx_i,
  input  logic                cipo_i,
  output logic                rx_push_o,
  output spi_solo_pkg::byte_t rx_byte_o
);
  import spi_solo_pkg::*;

  byte_t      shreg;
  logic [2:0] bit_cnt;
  logic       sample;

  assign sample = rise_tick_i && in_rx_i;

  // bit count and push strobe
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      bit_cnt   <= '0;
      rx_push_o <= 1'b0;
    end else begin
      // eighth bit lands with the count wrapping
      rx_push_o <= sample && (bit_cnt == 3'd7);
      if (!in_rx_i) begin
        bit_cnt <= '0;
      end else if (sample) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // msb arrives first, shifts in at the lsb
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (!in_rx_i) begin
      shreg <= '0;
    end else if (sample) begin
      shreg <= {shreg[6:0], cipo_i};
    end
  end

  assign rx_byte_o = shreg;

endmodule

//--- spi_bus_seq.sv
//////////////////////////////
// SPI frame sequencer
// command latch, bit-period timer and
// mode 0 frame FSM driving SCK, CSN, COPI
// and the transmit FIFO pop
//////////////////////////////
`timescale 1ns/1ps
`include "spi_solo_cfg.svh"

module spi_bus_seq (
  input  logic                   i_ext_spi_clk_x,
  input  logic                   i_srst,
  input  logic                   go_i,
  input  spi_solo_pkg::spi_cmd_t cmd_i,
  output logic                   idle_o,
  input  logic                   sck_lvl_i,
  input  logic                   fall_tick_i,
  input  spi_solo_pkg::byte_t    tx_head_i,
  input  logic                   tx_empty_i,
  output logic                   tx_pop_o,
  output logic                   in_rx_o,
  output spi_solo_pkg::spi_bus_t spi_o
);
  import spi_solo_pkg::*;

  // last timer value of each setup and hold state
  localparam timer_t SS_LAST = timer_t'(`SPI_SS_PERIODS - 1);

  // latched request
  spi_cmd_t   cmd_q;
  logic       pending_q;
  // frame FSM and its timer
  seq_state_e state_q;
  seq_state_e state_d;
  timer_t     timer_q;
  // last timer value of each data state
  timer_t     tx_last;
  timer_t     wait_last;
  timer_t     rx_last;
  logic       go_ok;
  logic       clk_run;

  ////////////////////////////// command latch
  // go only counts while idle with nothing latched
  assign go_ok  = go_i && idle_o;
  assign idle_o = (state_q == seq_idle) && !pending_q;

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (go_ok) begin
      cmd_q <= cmd_i;
    end
  end

  ////////////////////////////// state limits
  // 8 bits per byte, count is zero based
  assign tx_last   = {cmd_q.tx_len, 3'b000} - timer_t'(1);
  assign rx_last   = {cmd_q.rx_len, 3'b000} - timer_t'(1);
  assign wait_last = timer_t'(cmd_q.wait_cyc) - timer_t'(1);

  ////////////////////////////// frame FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      seq_idle: begin
        if (pending_q) state_d = seq_start_deselect;
      end
      seq_start_deselect: begin
        if (timer_q == SS_LAST) state_d = seq_start_select;
      end
      seq_start_select: begin
        if (timer_q == SS_LAST) state_d = seq_tx;
      end
      seq_tx: begin
        // skip wait and rx for a write-only frame
        if (timer_q == tx_last) begin
          if (cmd_q.rx_len == '0) begin
            state_d = seq_stop_select;
          end else if (cmd_q.wait_cyc == '0) begin
            state_d = seq_rx;
          end else begin
            state_d = seq_wait;
          end
        end
      end
      seq_wait: begin
        if (timer_q == wait_last) state_d = seq_rx;
      end
      seq_rx: begin
        if (timer_q == rx_last) state_d = seq_stop_select;
      end
      seq_stop_select: begin
        if (timer_q == SS_LAST) state_d = seq_stop_deselect;
      end
      seq_stop_deselect: begin
        if (timer_q == SS_LAST) state_d = seq_idle;
      end
      default: state_d = seq_idle;
    endcase
  end

  // state and timer move only on SCK falling ticks
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state_q   <= seq_idle;
      timer_q   <= '0;
      pending_q <= 1'b0;
    end else begin
      if (go_ok) begin
        pending_q <= 1'b1;
      end else if (fall_tick_i && (state_q == seq_idle)) begin
        // frame starts, request consumed
        pending_q <= 1'b0;
      end
      if (fall_tick_i) begin
        state_q <= state_d;
        if ((state_d != state_q) || (state_q == seq_idle)) begin
          timer_q <= '0;
        end else begin
          timer_q <= timer_q + timer_t'(1);
        end
      end
    end
  end

  ////////////////////////////// bus decode
  // clock runs through tx, wait and rx only
  assign clk_run = (state_q == seq_tx) || (state_q == seq_wait) || (state_q == seq_rx);
  assign in_rx_o = (state_q == seq_rx);

  always_comb begin
    spi_o.sck  = clk_run && sck_lvl_i;
    spi_o.csn  = (state_q == seq_idle) || (state_q == seq_start_deselect) ||
                 (state_q == seq_stop_deselect);
    spi_o.copi = 1'b0;
    // msb first from the FIFO head
    if ((state_q == seq_tx) && !tx_empty_i) begin
      spi_o.copi = tx_head_i[3'd7 - timer_q[2:0]];
    end
  end

  // pop on the fall tick closing each byte's last bit
  assign tx_pop_o = fall_tick_i && (state_q == seq_tx) && (timer_q[2:0] == 3'd7) &&
                    !tx_empty_i;

  ////////////////////////////// checks
  a_go_len : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    go_ok |-> (cmd_i.tx_len != '0))
    else $error("go accepted with zero tx length");

  // mode 0, clock parked low outside the select window
  a_sck_csn : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    spi_o.csn |-> !spi_o.sck)
    else $error("sck high while csn high");

endmodule

//--- spi_clk_phase.sv
//////////////////////////////
// SCK phase generator
// free-running phase count with
// level and edge tick decode
//////////////////////////////
`timescale 1ns/1ps
`include "spi_solo_cfg.svh"

module spi_clk_phase (
  input  logic i_ext_spi_clk_x,
  input  logic i_srst,
  output logic sck_lvl_o,
  output logic rise_tick_o,
  output logic fall_tick_o
);
  import spi_solo_pkg::*;

  localparam int HALF = `SPI_CLK_RATIO / 2;

  phase_t phase;

  // one step per system clock, wraps at the ratio
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      phase <= '0;
    end else if (phase == phase_t'(`SPI_CLK_RATIO - 1)) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // high half first, rising edge at phase 0
  assign sck_lvl_o   = (phase < phase_t'(HALF));
  assign rise_tick_o = (phase == '0);
  // falling edge in the middle of the period
  assign fall_tick_o = (phase == phase_t'(HALF));

  // edges must never coincide
  a_tick_excl : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    !(rise_tick_o && fall_tick_o))
    else $error("rise and fall tick together");

endmodule

//--- spi_sync_fifo.sv
//////////////////////////////
// synchronous byte FIFO
// first-word-fall-through head, writes
// dropped when full, reads ignored when empty
//////////////////////////////
`timescale 1ns/1ps
`include "spi_solo_cfg.svh"

module spi_sync_fifo #(
  parameter int DEPTH = `SPI_FIFO_DEPTH
) (
  input  logic                i_ext_spi_clk_x,
  input  logic                i_srst,
  input  logic                wr_i,
  input  spi_solo_pkg::byte_t wr_data_i,
  input  logic                rd_i,
  output spi_solo_pkg::byte_t rd_data_o,
  output logic                empty_o,
  output logic                full_o
);
  import spi_solo_pkg::*;

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // storage, no reset on payload
  byte_t                mem [DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [CNT_BITS-1:0]  count;
  logic                 do_wr;
  logic                 do_rd;

  // qualified strokes
  assign do_wr = wr_i && !full_o;
  assign do_rd = rd_i && !empty_o;

  assign empty_o   = (count == '0);
  assign full_o    = (count == CNT_BITS'(DEPTH));
  // head shown without a read latency
  assign rd_data_o = mem[rd_ptr];

  always_ff @(posedge i_ext_spi_clk_x) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  // pointers wrap at DEPTH, count tracks occupancy
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // occupancy stays in range across any push/pop mix
  a_count_range : assert property (@(posedge i_ext_spi_clk_x) disable iff (i_srst)
    count <= CNT_BITS'(DEPTH))
    else $error("fifo count above depth");

endmodule

//--- spi_solo_pkg.sv
//////////////////////////////
// spi solo shared types
// data vectors, command and bus structs,
// and the frame sequencer states
//////////////////////////////
`include "spi_solo_cfg.svh"

package spi_solo_pkg;

  ////////////////////////////// vectors
  // one data byte on the bus
  typedef logic [7:0] byte_t;
  // byte count for tx and rx
  typedef logic [`SPI_LEN_BITS-1:0] len_t;
  // wait in bit periods between tx and rx
  typedef logic [`SPI_WAIT_BITS-1:0] wait_t;
  // fall ticks counted within one state
  typedef logic [`SPI_TIMER_BITS-1:0] timer_t;
  // position within one SCK period
  typedef logic [$clog2(`SPI_CLK_RATIO)-1:0] phase_t;

  ////////////////////////////// structs
  // one frame request, latched on go
  typedef struct packed {
    len_t  tx_len;
    len_t  rx_len;
    wait_t wait_cyc;
  } spi_cmd_t;

  // mode 0 bus outputs toward the peripheral
  typedef struct packed {
    logic sck;
    logic csn;
    logic copi;
  } spi_bus_t;

  ////////////////////////////// states
  // frame order, idle first
  typedef enum logic [2:0] {
    seq_idle, seq_start_deselect, seq_start_select, seq_tx,
    seq_wait, seq_rx, seq_stop_select, seq_stop_deselect
  } seq_state_e;

endpackage

//--- spi_solo_cfg.svh
//////////////////////////////
// spi solo configuration
// clock ratio, field widths, FIFO depth
// and chip-select setup/hold periods
//////////////////////////////
`ifndef SPI_SOLO_CFG_SVH
`define SPI_SOLO_CFG_SVH

// system clocks per SCK period, even and at least 4
`define SPI_CLK_RATIO 8
// byte-count field width, up to 15 bytes
`define SPI_LEN_BITS 4
// wait field width, in bit periods
`define SPI_WAIT_BITS 2
// bit-period timer width, covers 8 x 15
`define SPI_TIMER_BITS 7
// SCK periods per setup and hold state
`define SPI_SS_PERIODS 4
// default entries per FIFO
`define SPI_FIFO_DEPTH 16

`endif
